//--- verilog/frontend_pkg.sv
package frontend_pkg;

  // Address widths.
  localparam int VADDR_W = 32;
  localparam int PADDR_W = 32;
  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [PADDR_W-1:0] paddr_t;

  // Pages are 256 bytes.
  localparam int PAGE_OFF_W = 8;
  typedef logic [VADDR_W-PAGE_OFF_W-1:0] vpage_t;
  typedef logic [PADDR_W-PAGE_OFF_W-1:0] ppage_t;

  // Cache line and direct-mapped geometry.
  localparam int LINE_B     = 16;
  localparam int LINE_OFF_W = 4;
  typedef logic [LINE_B*8-1:0] line_t;
  typedef logic [LINE_B-1:0]   line_be_t;
  localparam int IC_SETS    = 16;
  localparam int IC_INDEX_W = 4;
  localparam int IC_TAG_W   = PADDR_W - IC_INDEX_W - LINE_OFF_W;
  typedef logic [IC_TAG_W-1:0] ic_tag_t;

  // Instruction words inside a line.
  localparam int INST_B     = 4;
  localparam int LINE_WORDS = LINE_B / INST_B;
  localparam int WORD_IDX_W = 2;
  typedef logic [INST_B*8-1:0] inst_t;
  typedef logic [0:0]          inst_cat_t;
  localparam inst_cat_t CAT_NORMAL = 1'b0;
  localparam inst_cat_t CAT_FAULT  = 1'b1;

  // Instruction buffer depth and fetch throttle.
  localparam int IB_LINES    = 4;
  localparam int IB_PTR_W    = 2;
  localparam int IB_RDY_FREE = 3;

  localparam vaddr_t PC_INIT_VAL = 32'h0000_1000;

  // Fixed page map, no walker behind it.
  localparam int TLB_ENTRIES = 4;
  localparam vpage_t TLB_VPAGE [TLB_ENTRIES] = '{24'h10, 24'h11, 24'h12, 24'h13};
  localparam ppage_t TLB_PPAGE [TLB_ENTRIES] = '{24'h80, 24'h81, 24'h82, 24'h83};

  typedef struct packed {
    vaddr_t vaddr;
  } tlb_req_t;

  typedef struct packed {
    paddr_t paddr;
    logic   miss;
  } tlb_resp_t;

  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } ic_req_t;

  typedef struct packed {
    logic     valid;
    vaddr_t   addr;
    line_t    data;
    line_be_t be;
    logic     fault;
  } ic_resp_t;

  typedef struct packed {
    logic   valid;
    paddr_t paddr;
  } l2_req_t;

  typedef struct packed {
    logic  valid;
    line_t data;
  } l2_resp_t;

  typedef struct packed {
    logic      valid;
    vaddr_t    pc_addr;
    inst_cat_t cat;
    inst_t     inst;
  } disp_t;

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_REQ,
    IC_WAIT,
    IC_REFILL
  } ic_state_t;

endpackage

//--- verilog/itlb.sv
`timescale 1ns/1ps

module itlb import frontend_pkg::*; (
  input  tlb_req_t  i_tlb_req,
  output tlb_resp_t o_tlb_resp
);

  vpage_t                 w_vpage;
  ppage_t                 w_ppage;
  logic [TLB_ENTRIES-1:0] w_match;

  assign w_vpage = i_tlb_req.vaddr[VADDR_W-1:PAGE_OFF_W];

  // All entries compared at once.
  always_comb begin
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      w_match[i] = (w_vpage == TLB_VPAGE[i]);
    end
  end

  // AND-OR select of the physical page.
  // Entries are distinct, so at most one match is set.
  always_comb begin
    w_ppage = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      w_ppage = w_ppage | ({$bits(ppage_t){w_match[i]}} & TLB_PPAGE[i]);
    end
  end

  // Unmapped pages come out as page zero with the miss flag.
  assign o_tlb_resp.miss  = ~|w_match;
  assign o_tlb_resp.paddr = {w_ppage, i_tlb_req.vaddr[PAGE_OFF_W-1:0]};

endmodule

//--- verilog/icache.sv
`timescale 1ns/1ps

module icache import frontend_pkg::*; (
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  ic_req_t  i_s0_req,
  input  logic     i_fetch_enable,
  output logic     o_s0_ready,
  input  paddr_t   i_s1_paddr,
  input  logic     i_s1_tlb_miss,
  output ic_resp_t o_s2_resp,
  output l2_req_t  o_l2_req,
  input  logic     i_l2_req_ready,
  input  l2_resp_t i_l2_resp,
  output logic     o_s2_miss,
  output vaddr_t   o_s2_miss_vaddr
);

  ic_state_t             r_state;
  logic [IC_SETS-1:0]    r_valid;
  ic_tag_t               r_tag_ram  [IC_SETS];
  line_t                 r_data_ram [IC_SETS];

  logic                  w_s0_fire;
  logic [IC_INDEX_W-1:0] w_s0_index;

  logic                  r_s1_valid;
  vaddr_t                r_s1_vaddr;
  logic                  r_s1_line_vld;
  ic_tag_t               r_s1_tag;
  line_t                 r_s1_data;
  logic                  w_s1_hit;
  logic                  w_s1_miss;

  logic                  r_s2_valid;
  vaddr_t                r_s2_vaddr;
  line_t                 r_s2_data;
  line_be_t              r_s2_be;
  logic                  r_s2_fault;

  vaddr_t                r_miss_vaddr;
  paddr_t                r_miss_paddr;
  line_t                 r_refill_data;
  logic [IC_INDEX_W-1:0] w_refill_index;

  assign w_s0_index     = i_s0_req.vaddr[LINE_OFF_W +: IC_INDEX_W];
  assign w_refill_index = r_miss_paddr[LINE_OFF_W +: IC_INDEX_W];

  // Tag check against the translated address.
  assign w_s1_hit  = r_s1_line_vld && (r_s1_tag == i_s1_paddr[PADDR_W-1 -: IC_TAG_W]);
  assign w_s1_miss = r_s1_valid && !i_s1_tlb_miss && !w_s1_hit;

  // A miss in s1 also blocks the fetch sitting in s0.
  assign o_s0_ready = i_fetch_enable && (r_state == IC_IDLE) && !w_s1_miss;
  assign w_s0_fire  = i_s0_req.valid && o_s0_ready;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
    end else begin
      r_s1_valid <= w_s0_fire;
      r_s2_valid <= r_s1_valid && (i_s1_tlb_miss || w_s1_hit);
    end
  end

  // Arrays are read on acceptance.
  always_ff @(posedge i_clk) begin
    if (w_s0_fire) begin
      r_s1_vaddr    <= i_s0_req.vaddr;
      r_s1_line_vld <= r_valid[w_s0_index];
      r_s1_tag      <= r_tag_ram[w_s0_index];
      r_s1_data     <= r_data_ram[w_s0_index];
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_s1_valid) begin
      r_s2_vaddr <= r_s1_vaddr;
      r_s2_data  <= r_s1_data;
      // Bytes from the fetch offset up to the end of the line.
      r_s2_be    <= {LINE_B{1'b1}} << r_s1_vaddr[LINE_OFF_W-1:0];
      r_s2_fault <= i_s1_tlb_miss;
    end
  end

  assign o_s2_resp.valid = r_s2_valid;
  assign o_s2_resp.addr  = r_s2_vaddr;
  assign o_s2_resp.data  = r_s2_data;
  assign o_s2_resp.be    = r_s2_be;
  assign o_s2_resp.fault = r_s2_fault;

  // Refill machine, one miss outstanding.
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IC_IDLE;
      r_valid <= '0;
    end else begin
      case (r_state)
        IC_IDLE: begin
          if (w_s1_miss) begin
            r_state <= IC_REQ;
          end
        end
        IC_REQ: begin
          if (i_l2_req_ready) begin
            r_state <= IC_WAIT;
          end
        end
        IC_WAIT: begin
          if (i_l2_resp.valid) begin
            r_state <= IC_REFILL;
          end
        end
        IC_REFILL: begin
          r_valid[w_refill_index] <= 1'b1;
          r_state                 <= IC_IDLE;
        end
        default: begin
          r_state <= IC_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((r_state == IC_IDLE) && w_s1_miss) begin
      r_miss_vaddr <= r_s1_vaddr;
      r_miss_paddr <= {i_s1_paddr[PADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    end
    if ((r_state == IC_WAIT) && i_l2_resp.valid) begin
      r_refill_data <= i_l2_resp.data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_state == IC_REFILL) begin
      r_tag_ram[w_refill_index]  <= r_miss_paddr[PADDR_W-1 -: IC_TAG_W];
      r_data_ram[w_refill_index] <= r_refill_data;
    end
  end

  assign o_l2_req.valid  = (r_state == IC_REQ);
  assign o_l2_req.paddr  = r_miss_paddr;
  // Replay starts on the same edge that writes the line.
  assign o_s2_miss       = (r_state == IC_REFILL);
  assign o_s2_miss_vaddr = r_miss_vaddr;

endmodule

//--- verilog/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer import frontend_pkg::*; (
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  ic_resp_t i_inst,
  output logic     o_inst_rdy,
  output disp_t    o_disp,
  input  logic     i_disp_ready
);

  vaddr_t                r_pc    [IB_LINES];
  line_t                 r_data  [IB_LINES];
  line_be_t              r_be    [IB_LINES];
  logic                  r_fault [IB_LINES];

  logic [IB_PTR_W-1:0]   r_wr_ptr;
  logic [IB_PTR_W-1:0]   r_rd_ptr;
  logic [IB_PTR_W:0]     r_count;
  logic [WORD_IDX_W-1:0] r_word;

  logic [LINE_WORDS-1:0] w_word_en;
  logic [LINE_WORDS-1:0] w_above;
  logic [WORD_IDX_W-1:0] w_cur_word;
  logic                  w_more;
  logic                  w_push;
  logic                  w_fire;
  logic                  w_pop;

  // Room for the fetches still in s1 and s2 plus the one in s0.
  assign o_inst_rdy = (IB_LINES - int'(r_count)) >= IB_RDY_FREE;

  // Words of the head line not yet sent.
  always_comb begin
    for (int i = 0; i < LINE_WORDS; i++) begin
      w_word_en[i] = r_be[r_rd_ptr][INST_B*i] && (i >= int'(r_word));
    end
  end

  // Lowest pending word wins.
  always_comb begin
    w_cur_word = '0;
    for (int i = LINE_WORDS-1; i >= 0; i--) begin
      if (w_word_en[i]) begin
        w_cur_word = WORD_IDX_W'(i);
      end
    end
  end

  assign w_above = w_word_en >> w_cur_word;
  assign w_more  = |w_above[LINE_WORDS-1:1];

  assign w_push = i_inst.valid;
  assign w_fire = o_disp.valid && i_disp_ready;
  // A fault line is a single dispatch.
  assign w_pop  = w_fire && (r_fault[r_rd_ptr] || !w_more);

  always_comb begin
    o_disp.valid   = (r_count != '0);
    o_disp.cat     = r_fault[r_rd_ptr] ? CAT_FAULT : CAT_NORMAL;
    o_disp.pc_addr = {r_pc[r_rd_ptr][VADDR_W-1:LINE_OFF_W], w_cur_word, 2'b00};
    o_disp.inst    = r_data[r_rd_ptr][w_cur_word*$bits(inst_t) +: $bits(inst_t)];
    if (r_fault[r_rd_ptr]) begin
      o_disp.pc_addr = r_pc[r_rd_ptr];
      o_disp.inst    = '0;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
      r_word   <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
        r_word   <= '0;
      end else if (w_fire) begin
        r_word <= w_cur_word + 1'b1;
      end
      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_pc[r_wr_ptr]    <= i_inst.addr;
      r_data[r_wr_ptr]  <= i_inst.data;
      r_be[r_wr_ptr]    <= i_inst.be;
      r_fault[r_wr_ptr] <= i_inst.fault;
    end
  end

endmodule

//--- verilog/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend import frontend_pkg::*; (
  input  logic     i_clk,
  input  logic     i_reset_n,
  output l2_req_t  o_l2_req,
  input  logic     i_l2_req_ready,
  input  l2_resp_t i_l2_resp,
  output disp_t    o_disp,
  input  logic     i_disp_ready
);

  vaddr_t    r_s0_vaddr;
  tlb_req_t  w_s0_tlb_req;
  tlb_resp_t w_s0_tlb_resp;
  ic_req_t   w_s0_ic_req;
  logic      w_s0_ic_ready;

  paddr_t    r_s1_paddr;
  logic      r_s1_tlb_miss;

  ic_resp_t  w_s2_ic_resp;
  logic      w_s2_ic_miss;
  vaddr_t    w_s2_ic_miss_vaddr;
  logic      w_inst_rdy;

  // Fetch PC, one line per accepted fetch.
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s0_vaddr <= PC_INIT_VAL;
    end else if (w_s2_ic_miss) begin
      r_s0_vaddr <= w_s2_ic_miss_vaddr;
    end else if (w_s0_ic_ready) begin
      r_s0_vaddr <= {r_s0_vaddr[VADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}} + vaddr_t'(LINE_B);
    end
  end

  assign w_s0_tlb_req.vaddr = r_s0_vaddr;

  itlb u_itlb (
    .i_tlb_req  (w_s0_tlb_req),
    .o_tlb_resp (w_s0_tlb_resp)
  );

  // Translation lines up with the icache s1 stage.
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_paddr    <= '0;
      r_s1_tlb_miss <= 1'b0;
    end else begin
      r_s1_paddr    <= w_s0_tlb_resp.paddr;
      r_s1_tlb_miss <= w_s0_tlb_resp.miss;
    end
  end

  assign w_s0_ic_req.valid = 1'b1;
  assign w_s0_ic_req.vaddr = r_s0_vaddr;

  icache u_icache (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_s0_req        (w_s0_ic_req),
    .i_fetch_enable  (w_inst_rdy),
    .o_s0_ready      (w_s0_ic_ready),
    .i_s1_paddr      (r_s1_paddr),
    .i_s1_tlb_miss   (r_s1_tlb_miss),
    .o_s2_resp       (w_s2_ic_resp),
    .o_l2_req        (o_l2_req),
    .i_l2_req_ready  (i_l2_req_ready),
    .i_l2_resp       (i_l2_resp),
    .o_s2_miss       (w_s2_ic_miss),
    .o_s2_miss_vaddr (w_s2_ic_miss_vaddr)
  );

  inst_buffer u_inst_buffer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_inst       (w_s2_ic_resp),
    .o_inst_rdy   (w_inst_rdy),
    .o_disp       (o_disp),
    .i_disp_ready (i_disp_ready)
  );

endmodule

//--- tests/fetch_frontend_checker.sv
`timescale 1ns/1ps

module fetch_frontend_checker import frontend_pkg::*; (
  input logic      i_clk,
  input logic      i_reset_n,
  input l2_req_t   i_l2_req,
  input logic      i_l2_req_ready,
  input disp_t     i_disp,
  input logic      i_disp_ready,
  input ic_state_t i_ic_state
);

  int n_disp_hold   = 0;
  int n_fault_addr  = 0;
  int n_disp_mapped = 0;
  int n_l2_hold     = 0;
  int n_l2_addr     = 0;
  int n_fault_idle  = 0;
  int fail_total;

  assign fail_total = n_disp_hold + n_fault_addr + n_disp_mapped + n_l2_hold + n_l2_addr
                    + n_fault_idle;

  // Stalled dispatch keeps every field.
  a_disp_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_disp.valid && !i_disp_ready) |=> $stable(i_disp))
    else begin
      n_disp_hold++;
      $error("dispatch changed while stalled");
    end

  // Fault entries start a line outside the mapped pages.
  a_fault_addr: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_disp.valid && i_disp.cat == CAT_FAULT) |->
      (i_disp.pc_addr[3:0] == 4'h0
       && (i_disp.pc_addr[31:8] < 24'h10 || i_disp.pc_addr[31:8] > 24'h13)))
    else begin
      n_fault_addr++;
      $error("fault dispatch unaligned or inside a mapped page");
    end

  // Normal instructions only come from the virtual pages 0x10 to 0x13.
  a_disp_mapped: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_disp.valid && i_disp.cat == CAT_NORMAL) |->
      (i_disp.pc_addr[31:8] >= 24'h10 && i_disp.pc_addr[31:8] <= 24'h13))
    else begin
      n_disp_mapped++;
      $error("normal dispatch from an unmapped page");
    end

  // Request stays up with the same address until taken.
  a_l2_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_l2_req.valid && !i_l2_req_ready) |=> (i_l2_req.valid && $stable(i_l2_req.paddr)))
    else begin
      n_l2_hold++;
      $error("l2 request dropped or changed before ready");
    end

  // Only the mapped physical pages 0x80 to 0x83 reach L2.
  a_l2_addr: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_l2_req.valid |-> (i_l2_req.paddr[3:0] == 4'h0 && i_l2_req.paddr[31:8] >= 24'h80
                        && i_l2_req.paddr[31:8] <= 24'h83))
    else begin
      n_l2_addr++;
      $error("l2 request address unaligned or outside mapped pages");
    end

  // Unmapped lines never start a refill.
  a_fault_idle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_disp.valid && i_disp.cat == CAT_FAULT) |-> (i_ic_state == IC_IDLE))
    else begin
      n_fault_idle++;
      $error("refill running while fault lines are dispatched");
    end

endmodule

bind fetch_frontend fetch_frontend_checker u_checker (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_l2_req       (o_l2_req),
  .i_l2_req_ready (i_l2_req_ready),
  .i_disp         (o_disp),
  .i_disp_ready   (i_disp_ready),
  .i_ic_state     (u_icache.r_state)
);

//--- tests/fetch_frontend_tb.sv
`timescale 1ns/1ps

module fetch_frontend_tb import frontend_pkg::*; ();

  // Four mapped pages of 64 words each, then unmapped lines.
  localparam int N_NORMAL = TLB_ENTRIES * (1 << PAGE_OFF_W) / INST_B;
  localparam int N_LINES  = N_NORMAL / LINE_WORDS;
  localparam int N_FAULTS = 8;
  // 64 refills of up to about 20 cycles plus stalls, with a wide margin.
  localparam int TIMEOUT_CYCLES = 40000;
  localparam logic [31:0] DATA_KEY = 32'h5a5a_0000;

  logic     i_clk;
  logic     i_reset_n;
  l2_req_t  o_l2_req;
  logic     i_l2_req_ready;
  l2_resp_t i_l2_resp;
  disp_t    o_disp;
  logic     i_disp_ready;

  logic [31:0] rng = 32'hc165;
  int          cycle_cnt = 0;
  int          normal_cnt = 0;
  int          fault_cnt = 0;
  int          l2_cnt = 0;
  int          resp_wait = 0;
  vaddr_t      exp_pc = PC_INIT_VAL;
  vaddr_t      exp_fault_pc = PC_INIT_VAL + vaddr_t'(N_NORMAL * INST_B);
  paddr_t      last_l2_paddr = '0;
  paddr_t      accepted_paddr = '0;
  line_t       resp_line = '0;
  logic        l2_accepted = 1'b0;
  logic        l2_stalled = 1'b0;
  l2_req_t     stalled_req;
  logic        disp_stalled = 1'b0;
  disp_t       stalled_disp;

  int checks_reset = 0;
  int err_reset = 0;
  int checks_order = 0;
  int err_order = 0;
  int checks_hold = 0;
  int err_hold = 0;
  int checks_l2 = 0;
  int err_l2 = 0;
  int checks_fault = 0;
  int err_fault = 0;

  fetch_frontend uut (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .o_l2_req       (o_l2_req),
    .i_l2_req_ready (i_l2_req_ready),
    .i_l2_resp      (i_l2_resp),
    .o_disp         (o_disp),
    .i_disp_ready   (i_disp_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift_next(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Memory word is its physical address with the data key.
  function automatic line_t l2_line_data(input paddr_t base);
    line_t l;
    for (int w = 0; w < LINE_WORDS; w++) begin
      l[w*32 +: 32] = (base + paddr_t'(4 * w)) ^ DATA_KEY;
    end
    return l;
  endfunction

  // Mapped pages sit 0x70 pages higher in physical space.
  function automatic inst_t expected_inst(input vaddr_t pc);
    paddr_t pa;
    pa = {pc[31:8] + 24'h70, pc[7:0]};
    return pa ^ DATA_KEY;
  endfunction

  function automatic int report_test(input string name, input int checks, input int errs);
    $display("test %s: %0d checks, %0d errors, %s", name, checks, errs,
             (errs == 0) ? "ok" : "failed");
    return (errs == 0) ? 0 : 1;
  endfunction

  task automatic check_reset_outputs();
    checks_reset++;
    assert (!o_disp.valid && !o_l2_req.valid && !uut.w_s2_ic_miss) else begin
      $display("mismatch disp/l2/miss valid: got %h%h%h expected 000",
               o_disp.valid, o_l2_req.valid, uut.w_s2_ic_miss);
      err_reset++;
    end
  endtask

  task automatic check_dispatch();
    if (normal_cnt < N_NORMAL) begin
      checks_order++;
      assert (o_disp.pc_addr == exp_pc) else begin
        $display("mismatch o_disp.pc_addr: got %h expected %h", o_disp.pc_addr, exp_pc);
        err_order++;
      end
      assert (o_disp.inst == expected_inst(exp_pc)) else begin
        $display("mismatch o_disp.inst: got %h expected %h", o_disp.inst,
                 expected_inst(exp_pc));
        err_order++;
      end
      assert (o_disp.cat == 1'b0) else begin
        $display("mismatch o_disp.cat: got %h expected 0", o_disp.cat);
        err_order++;
      end
      exp_pc = exp_pc + vaddr_t'(INST_B);
      normal_cnt++;
    end else if (fault_cnt < N_FAULTS) begin
      checks_fault++;
      assert (o_disp.pc_addr == exp_fault_pc && o_disp.cat == 1'b1 && o_disp.inst == '0)
      else begin
        $display("mismatch o_disp pc/cat/inst: got %h/%h/%h expected %h/1/0",
                 o_disp.pc_addr, o_disp.cat, o_disp.inst, exp_fault_pc);
        err_fault++;
      end
      exp_fault_pc = exp_fault_pc + vaddr_t'(LINE_B);
      fault_cnt++;
    end
  endtask

  task automatic check_l2_request();
    checks_l2++;
    assert (o_l2_req.paddr[LINE_OFF_W-1:0] == '0) else begin
      $display("mismatch o_l2_req.paddr[3:0]: got %h expected 0",
               o_l2_req.paddr[LINE_OFF_W-1:0]);
      err_l2++;
    end
    assert (o_l2_req.paddr[31:8] >= 24'h80 && o_l2_req.paddr[31:8] <= 24'h83) else begin
      $display("l2 request %h lies outside physical pages 80 to 83", o_l2_req.paddr);
      err_l2++;
    end
    assert (l2_cnt == 0 || o_l2_req.paddr > last_l2_paddr) else begin
      $display("l2 request %h is not above the previous one %h", o_l2_req.paddr,
               last_l2_paddr);
      err_l2++;
    end
    last_l2_paddr  = o_l2_req.paddr;
    accepted_paddr = o_l2_req.paddr;
    l2_cnt++;
  endtask

  // Sampled mid-cycle, where outputs and driven inputs have settled.
  task automatic check_outputs();
    if (disp_stalled) begin
      checks_hold++;
      assert (o_disp == stalled_disp) else begin
        $display("mismatch o_disp: got %h expected %h", o_disp, stalled_disp);
        err_hold++;
      end
    end
    disp_stalled = o_disp.valid && !i_disp_ready;
    stalled_disp = o_disp;
    if (o_disp.valid && i_disp_ready) begin
      check_dispatch();
    end
    if (l2_stalled) begin
      checks_l2++;
      assert (o_l2_req == stalled_req) else begin
        $display("mismatch o_l2_req: got %h expected %h", o_l2_req, stalled_req);
        err_l2++;
      end
    end
    l2_stalled  = o_l2_req.valid && !i_l2_req_ready;
    stalled_req = o_l2_req;
    l2_accepted = o_l2_req.valid && i_l2_req_ready;
    if (l2_accepted) begin
      check_l2_request();
    end
    if (normal_cnt == N_NORMAL) begin
      checks_fault++;
      assert (!o_l2_req.valid) else begin
        $display("l2 request %h raised after the mapped range", o_l2_req.paddr);
        err_fault++;
      end
    end
  endtask

  // L2 model with one refill in flight and random dispatch ready.
  task automatic drive_inputs();
    i_l2_resp.valid = 1'b0;
    if (l2_accepted) begin
      rng       = xorshift_next(rng);
      resp_wait = int'(rng % 32'd8) + 1;
      resp_line = l2_line_data(accepted_paddr);
    end else if (resp_wait > 0) begin
      resp_wait--;
      if (resp_wait == 0) begin
        i_l2_resp.valid = 1'b1;
        i_l2_resp.data  = resp_line;
      end
    end
    rng            = xorshift_next(rng);
    i_l2_req_ready = rng[3];
    rng            = xorshift_next(rng);
    i_disp_ready   = (rng % 32'd10) < 32'd7;
  endtask

  initial begin : stream
    i_l2_req_ready = 1'b0;
    i_l2_resp      = '0;
    i_disp_ready   = 1'b0;
    wait (i_reset_n === 1'b1);
    forever begin
      @(negedge i_clk);
      check_outputs();
      @(posedge i_clk);
      #1;
      drive_inputs();
    end
  end

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d normal and %0d fault dispatches",
               cycle_cnt, normal_cnt, fault_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin : main
    int extra_hold;
    int extra_l2;
    int fail_tests;
    int total_err;
    extra_hold = 0;
    extra_l2   = 0;
    fail_tests = 0;
    i_reset_n  = 1'b0;
    repeat (3) begin
      @(negedge i_clk);
      check_reset_outputs();
    end
    @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    @(negedge i_clk);
    check_reset_outputs();
    fail_tests += report_test("reset state", checks_reset, err_reset);

    wait (normal_cnt == N_NORMAL);
    fail_tests += report_test("dispatch order and content", checks_order, err_order);
    assert (checks_hold > 0) else begin
      $display("back-pressure never stalled a valid dispatch");
      extra_hold = 1;
    end
    fail_tests += report_test("back-pressure", checks_hold, err_hold + extra_hold);
    assert (l2_cnt == N_LINES) else begin
      $display("expected %0d l2 requests but saw %0d", N_LINES, l2_cnt);
      extra_l2 = 1;
    end
    fail_tests += report_test("l2 discipline", checks_l2, err_l2 + extra_l2);

    wait (fault_cnt == N_FAULTS);
    fail_tests += report_test("fetch faults", checks_fault, err_fault);

    total_err = err_reset + err_order + err_hold + extra_hold + err_l2 + extra_l2
              + err_fault + uut.u_checker.fail_total;
    $display("summary: %0d of 5 tests failed, %0d errors, %0d checker failures, %0d cycles",
             fail_tests, total_err, uut.u_checker.fail_total, cycle_cnt);
    if (total_err == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
verilog/frontend_pkg.sv
verilog/itlb.sv
verilog/icache.sv
verilog/inst_buffer.sv
verilog/fetch_frontend.sv
tests/fetch_frontend_checker.sv
tests/fetch_frontend_tb.sv

//--- Makefile
# Verilator build and run for the fetch front end testbench.

VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TESTBENCH PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
